// File: logic/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  // bits per colour channel, three channels make the 12-bit colour
  localparam int COLOR_BITS = 4;
  // per-pixel metadata, e.g. intensity for vector-display fade
  localparam int META_BITS  = 4;
  // x and y width, geometry is limited to 256x256
  localparam int COORD_BITS = 8;

  // framebuffer word address and AXI data widths
  localparam int ADDR_BITS  = 16;
  // one data word holds exactly one pixel
  localparam int DATA_BITS  = 16;

  typedef struct packed {
    logic [COLOR_BITS-1:0] red;
    logic [COLOR_BITS-1:0] grn;
    logic [COLOR_BITS-1:0] blu;
    logic [ META_BITS-1:0] meta;
  } pixel_t;

  // drawing client request
  typedef struct packed {
    logic [COORD_BITS-1:0] x;
    logic [COORD_BITS-1:0] y;
    pixel_t                pixel;
  } gfx_req_t;

  // one output pixel period, syncs are active low
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    pixel_t pixel;
  } vga_beat_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

endpackage

`default_nettype wire

// File: logic/fb_writer.sv
`timescale 1ns/1ps
`default_nettype none

module fb_writer
  import gfx_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic [ADDR_BITS-1:0] req_addr,
  input  pixel_t               req_pixel,
  input  logic                 req_valid,
  output logic                 req_ready,

  output logic [ADDR_BITS-1:0] awaddr,
  output logic                 awvalid,
  input  logic                 awready,
  output logic [DATA_BITS-1:0] wdata,
  output logic                 wvalid,
  input  logic                 wready,
  input  logic                 bvalid,
  input  axi_resp_t            bresp,
  output logic                 bready
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_RESP
  } wr_state_t;

  wr_state_t state;
  logic      aw_done;
  logic      w_done;
  logic      aw_fire;
  logic      w_fire;

  assign req_ready = (state == WR_IDLE);
  // each channel drops its valid once its own handshake is done
  assign awvalid   = (state == WR_SEND) && !aw_done;
  assign wvalid    = (state == WR_SEND) && !w_done;
  assign bready    = (state == WR_RESP);
  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= WR_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        WR_IDLE: begin
          if (req_valid) begin
            state   <= WR_SEND;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        WR_SEND: begin
          if (aw_fire) begin
            aw_done <= 1'b1;
          end
          if (w_fire) begin
            w_done <= 1'b1;
          end
          // AW and W may finish in either order
          if ((aw_fire || aw_done) && (w_fire || w_done)) begin
            state <= WR_RESP;
          end
        end
        WR_RESP: begin
          // SLVERR marks an address outside the frame and needs no retry
          if (bvalid) begin
            state <= WR_IDLE;
          end
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      awaddr <= req_addr;
      wdata  <= req_pixel;
    end
  end

endmodule

`default_nettype wire

// File: logic/fb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module fb_memory
  import gfx_pkg::*;
#(
  parameter int DEPTH = 128
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // write channels
  input  logic [ADDR_BITS-1:0] awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [DATA_BITS-1:0] wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output logic                 bvalid,
  output axi_resp_t            bresp,
  input  logic                 bready,

  // read channels
  input  logic [ADDR_BITS-1:0] araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic [DATA_BITS-1:0] rdata,
  output axi_resp_t            rresp,
  output logic                 rvalid,
  input  logic                 rready
);

  localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_BITS-1:0] mem [DEPTH];

  logic wr_fire;
  logic rd_fire;
  logic wr_in_range;
  logic rd_in_range;

  // address and data are taken together, one write outstanding
  assign wr_fire     = awvalid && wvalid && !bvalid;
  assign awready     = wr_fire;
  assign wready      = wr_fire;
  assign wr_in_range = (awaddr < ADDR_BITS'(DEPTH));

  assign arready     = !rvalid;
  assign rd_fire     = arvalid && arready;
  assign rd_in_range = (araddr < ADDR_BITS'(DEPTH));

  always_ff @(posedge clk) begin
    if (wr_fire && wr_in_range) begin
      mem[awaddr[IDX_BITS-1:0]] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_in_range ? OKAY : SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // out of range reads return zero
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_in_range ? mem[araddr[IDX_BITS-1:0]] : '0;
      rresp <= rd_in_range ? OKAY : SLVERR;
    end
  end

endmodule

`default_nettype wire

// File: logic/vga_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module vga_scanner
  import gfx_pkg::*;
#(
  parameter int H_VISIBLE = 16,
  parameter int H_FRONT   = 2,
  parameter int H_SYNC    = 3,
  parameter int H_BACK    = 3,
  parameter int V_VISIBLE = 8,
  parameter int V_FRONT   = 1,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable,

  output logic [ADDR_BITS-1:0] araddr,
  output logic                 arvalid,
  input  logic                 arready,
  input  logic [DATA_BITS-1:0] rdata,
  input  logic                 rvalid,
  input  axi_resp_t            rresp,
  output logic                 rready,

  input  logic                 almost_full,
  output logic                 push,
  output vga_beat_t            beat
);

  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_BITS  = $clog2(H_TOTAL + 1);
  localparam int V_BITS  = $clog2(V_TOTAL + 1);

  typedef enum logic [1:0] {
    SC_POS,
    SC_DATA,
    SC_PUSH
  } sc_state_t;

  sc_state_t            state;
  logic [H_BITS-1:0]    col;
  logic [V_BITS-1:0]    line;
  logic [ADDR_BITS-1:0] fb_addr;
  pixel_t               pix_q;
  logic                 visible;
  logic                 in_hsync;
  logic                 in_vsync;

  assign visible  = (col < H_BITS'(H_VISIBLE)) && (line < V_BITS'(V_VISIBLE));
  assign in_hsync = (col >= H_BITS'(H_VISIBLE + H_FRONT)) &&
                    (col < H_BITS'(H_VISIBLE + H_FRONT + H_SYNC));
  assign in_vsync = (line >= V_BITS'(V_VISIBLE + V_FRONT)) &&
                    (line < V_BITS'(V_VISIBLE + V_FRONT + V_SYNC));

  assign araddr  = fb_addr;
  assign arvalid = (state == SC_POS) && enable && visible;
  assign rready  = (state == SC_DATA);

  // blanking positions push straight from SC_POS
  assign push = !almost_full &&
                ((state == SC_PUSH) || ((state == SC_POS) && enable && !visible));

  assign beat.hsync = !in_hsync;
  assign beat.vsync = !in_vsync;
  assign beat.pixel = (state == SC_PUSH) ? pix_q : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SC_POS;
    end else begin
      case (state)
        SC_POS:  if (arvalid && arready) state <= SC_DATA;
        SC_DATA: if (rvalid) state <= SC_PUSH;
        SC_PUSH: if (push) state <= SC_POS;
        default: state <= SC_POS;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == SC_DATA) && rvalid) begin
      pix_q <= (rresp == OKAY) ? pixel_t'(rdata) : '0;
    end
  end

  // raster position and linear framebuffer address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col     <= '0;
      line    <= '0;
      fb_addr <= '0;
    end else if (push) begin
      if (visible) begin
        fb_addr <= fb_addr + 1'b1;
      end
      if (col == H_BITS'(H_TOTAL - 1)) begin
        col <= '0;
        if (line == V_BITS'(V_TOTAL - 1)) begin
          line    <= '0;
          fb_addr <= '0;
        end else begin
          line <= line + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
  parameter type payload_t       = logic [15:0],
  parameter int  DEPTH           = 16,
  parameter int  ALMOST_FULL_GAP = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     almost_full
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  payload_t            mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push     = push && (count != CNT_BITS'(DEPTH));
  assign do_pop      = pop && !empty;
  assign empty       = (count == '0);
  // leaves room for the beat the producer may already have in flight
  assign almost_full = (count >= CNT_BITS'(DEPTH - ALMOST_FULL_GAP));
  assign pop_data    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/gfx_display.sv
`timescale 1ns/1ps
`default_nettype none

module gfx_display
  import gfx_pkg::*;
#(
  parameter int H_VISIBLE  = 16,
  parameter int H_FRONT    = 2,
  parameter int H_SYNC     = 3,
  parameter int H_BACK     = 3,
  parameter int V_VISIBLE  = 8,
  parameter int V_FRONT    = 1,
  parameter int V_SYNC     = 2,
  parameter int V_BACK     = 1,
  parameter int FIFO_DEPTH = 16
) (
  input  logic      clk,
  input  logic      rst_n,

  input  gfx_req_t  gfx_req,
  input  logic      gfx_valid,
  output logic      gfx_ready,

  input  logic      vga_enable,
  input  logic      pixel_ce,
  output vga_beat_t vga_out,
  output logic      underrun
);

  localparam vga_beat_t BLANK_BEAT = '{hsync: 1'b1, vsync: 1'b1, pixel: '0};

  logic [ADDR_BITS-1:0] lin_addr;
  logic                 req_valid;
  logic                 req_ready;
  logic [ADDR_BITS-1:0] req_addr;
  pixel_t               req_pixel;

  logic [ADDR_BITS-1:0] awaddr;
  logic                 awvalid;
  logic                 awready;
  logic [DATA_BITS-1:0] wdata;
  logic                 wvalid;
  logic                 wready;
  logic                 bvalid;
  axi_resp_t            bresp;
  logic                 bready;
  logic [ADDR_BITS-1:0] araddr;
  logic                 arvalid;
  logic                 arready;
  logic [DATA_BITS-1:0] rdata;
  axi_resp_t            rresp;
  logic                 rvalid;
  logic                 rready;

  logic                 fifo_push;
  vga_beat_t            fifo_in;
  logic                 fifo_pop;
  vga_beat_t            fifo_out;
  logic                 fifo_empty;
  logic                 fifo_almost_full;
  logic                 streaming;

  // one-entry request slot, ready only while empty
  assign gfx_ready = !req_valid;
  assign lin_addr  = ADDR_BITS'(gfx_req.y) * ADDR_BITS'(H_VISIBLE) + ADDR_BITS'(gfx_req.x);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else if (gfx_valid && gfx_ready) begin
      req_valid <= 1'b1;
    end else if (req_ready) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (gfx_valid && gfx_ready) begin
      req_addr  <= lin_addr;
      req_pixel <= gfx_req.pixel;
    end
  end

  fb_writer u_fb_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_addr  (req_addr),
    .req_pixel (req_pixel),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready)
  );

  fb_memory #(
    .DEPTH (H_VISIBLE * V_VISIBLE)
  ) u_fb_memory (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  vga_scanner #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK)
  ) u_vga_scanner (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (vga_enable),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .rresp       (rresp),
    .rready      (rready),
    .almost_full (fifo_almost_full),
    .push        (fifo_push),
    .beat        (fifo_in)
  );

  beat_fifo #(
    .payload_t       (vga_beat_t),
    .DEPTH           (FIFO_DEPTH),
    .ALMOST_FULL_GAP (2)
  ) u_beat_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push        (fifo_push),
    .push_data   (fifo_in),
    .pop         (fifo_pop),
    .pop_data    (fifo_out),
    .empty       (fifo_empty),
    .almost_full (fifo_almost_full)
  );

  assign fifo_pop = pixel_ce && !fifo_empty;

  // an empty FIFO only counts as underrun once the stream has started
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_out   <= BLANK_BEAT;
      streaming <= 1'b0;
      underrun  <= 1'b0;
    end else if (pixel_ce) begin
      if (!fifo_empty) begin
        vga_out   <= fifo_out;
        streaming <= 1'b1;
      end else begin
        vga_out <= BLANK_BEAT;
        if (streaming) begin
          underrun <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_gfx_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_display
  import gfx_pkg::*;
();

  localparam int H_VISIBLE   = 16;
  localparam int H_FRONT     = 2;
  localparam int H_SYNC      = 3;
  localparam int H_BACK      = 3;
  localparam int V_VISIBLE   = 8;
  localparam int V_FRONT     = 1;
  localparam int V_SYNC      = 2;
  localparam int V_BACK      = 1;
  localparam int H_TOTAL     = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL     = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int FB_WORDS    = H_VISIBLE * V_VISIBLE;
  localparam int FRAME_BEATS = H_TOTAL * V_TOTAL;
  localparam int CHECK_BEATS = 2 * FRAME_BEATS;
  localparam int CLK_PERIOD  = 8;
  localparam int MAX_GAP     = 11;
  // write phase plus three frames at the longest pixel_ce gap and some slack
  localparam int WRITE_CYCLES = FB_WORDS * 8 + 200;
  localparam int TIMEOUT_NS   = (WRITE_CYCLES + 3 * FRAME_BEATS * (MAX_GAP + 1)) * CLK_PERIOD;

  logic      clk;
  logic      rst_n;
  gfx_req_t  gfx_req;
  logic      gfx_valid;
  logic      gfx_ready;
  logic      vga_enable;
  logic      pixel_ce;
  vga_beat_t vga_out;
  logic      underrun;

  integer    seed;
  pixel_t    mirror [FB_WORDS];
  int        xfer_count;
  int        pos_count;
  logic      ce_q;
  logic      ce_run;
  int        gap;
  int        frame_pos;
  logic      in_first;
  logic      in_view;
  vga_beat_t exp_beat;

  int reset_errors;
  int flow_errors;
  int contents_errors;
  int sync_errors;
  int rewrite_errors;
  int failed_tests;
  int total_errors;

  gfx_display #(
    .H_VISIBLE  (H_VISIBLE),
    .H_FRONT    (H_FRONT),
    .H_SYNC     (H_SYNC),
    .H_BACK     (H_BACK),
    .V_VISIBLE  (V_VISIBLE),
    .V_FRONT    (V_FRONT),
    .V_SYNC     (V_SYNC),
    .V_BACK     (V_BACK),
    .FIFO_DEPTH (16)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .gfx_req    (gfx_req),
    .gfx_valid  (gfx_valid),
    .gfx_ready  (gfx_ready),
    .vga_enable (vga_enable),
    .pixel_ce   (pixel_ce),
    .vga_out    (vga_out),
    .underrun   (underrun)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // syncs are active low; only visible positions carry framebuffer data
  function automatic vga_beat_t expected_beat(input int pos, input pixel_t fb [FB_WORDS]);
    int        col;
    int        row;
    vga_beat_t b;
    col     = pos % H_TOTAL;
    row     = pos / H_TOTAL;
    b.hsync = !((col >= H_VISIBLE + H_FRONT) && (col < H_VISIBLE + H_FRONT + H_SYNC));
    b.vsync = !((row >= V_VISIBLE + V_FRONT) && (row < V_VISIBLE + V_FRONT + V_SYNC));
    if ((col < H_VISIBLE) && (row < V_VISIBLE)) begin
      b.pixel = fb[row * H_VISIBLE + col];
    end else begin
      b.pixel = '0;
    end
    return b;
  endfunction

  function automatic pixel_t random_pixel();
    logic [31:0] rnd;
    rnd = $random(seed);
    return pixel_t'(rnd[15:0]);
  endfunction

  // starts at a falling edge and returns at the falling edge after the transfer
  task automatic send_pixel(input int x, input int y, input pixel_t pix);
    logic ready_seen;
    logic accepted;
    gfx_req.x     = COORD_BITS'(x);
    gfx_req.y     = COORD_BITS'(y);
    gfx_req.pixel = pix;
    gfx_valid     = 1'b1;
    accepted      = 1'b0;
    while (!accepted) begin
      ready_seen = gfx_ready;
      @(negedge clk);
      accepted = ready_seen;
    end
    assert (gfx_ready == 1'b0) else begin
      $display("Mismatch gfx_ready after transfer (%0d,%0d): got %h expected %h",
               x, y, gfx_ready, 1'b0);
      flow_errors++;
    end
  endtask

  task automatic note_beat_error(input logic first_frame, input logic pixel_in_view);
    if (!first_frame) begin
      rewrite_errors++;
    end else if (pixel_in_view) begin
      contents_errors++;
    end else begin
      sync_errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0) begin
      $display("test %-16s PASS", name);
    end else begin
      $display("test %-16s FAIL (%0d errors)", name, errors);
      failed_tests++;
    end
  endtask

  // mirror every accepted client write
  always @(posedge clk) begin
    if (rst_n && gfx_valid && gfx_ready) begin
      mirror[int'(gfx_req.y) * H_VISIBLE + int'(gfx_req.x)] <= gfx_req.pixel;
      xfer_count <= xfer_count + 1;
    end
  end

  always @(posedge clk) begin
    ce_q <= pixel_ce;
  end

  // compare on the cycle after each pixel_ce
  always @(negedge clk) begin
    if (ce_q && (pos_count < CHECK_BEATS)) begin
      frame_pos = pos_count % FRAME_BEATS;
      exp_beat  = expected_beat(frame_pos, mirror);
      in_first  = (pos_count < FRAME_BEATS);
      in_view   = ((frame_pos % H_TOTAL) < H_VISIBLE) && ((frame_pos / H_TOTAL) < V_VISIBLE);
      assert (vga_out.hsync == exp_beat.hsync) else begin
        $display("Mismatch vga_out.hsync at beat %0d: got %h expected %h",
                 pos_count, vga_out.hsync, exp_beat.hsync);
        note_beat_error(in_first, 1'b0);
      end
      assert (vga_out.vsync == exp_beat.vsync) else begin
        $display("Mismatch vga_out.vsync at beat %0d: got %h expected %h",
                 pos_count, vga_out.vsync, exp_beat.vsync);
        note_beat_error(in_first, 1'b0);
      end
      assert (vga_out.pixel == exp_beat.pixel) else begin
        $display("Mismatch vga_out.pixel at beat %0d: got %h expected %h",
                 pos_count, vga_out.pixel, exp_beat.pixel);
        note_beat_error(in_first, in_view);
      end
      assert (underrun == 1'b0) else begin
        $display("underrun flag set at beat %0d, the output FIFO ran empty", pos_count);
        rewrite_errors++;
      end
      pos_count = pos_count + 1;
    end
  end

  // pixel_ce pulses with a random spacing of 4 to 11 cycles
  initial begin
    wait (ce_run);
    forever begin
      @(negedge clk);
      pixel_ce = 1'b1;
      @(negedge clk);
      pixel_ce = 1'b0;
      gap = 4 + int'($unsigned($random(seed)) % 8);
      repeat (gap - 2) @(negedge clk);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the display did not deliver two frames of beats in time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed            = 32'h41ed1d65;
    clk             = 1'b0;
    rst_n           = 1'b0;
    gfx_req         = '0;
    gfx_valid       = 1'b0;
    vga_enable      = 1'b0;
    pixel_ce        = 1'b0;
    ce_run          = 1'b0;
    xfer_count      = 0;
    pos_count       = 0;
    reset_errors    = 0;
    flow_errors     = 0;
    contents_errors = 0;
    sync_errors     = 0;
    rewrite_errors  = 0;
    failed_tests    = 0;
    total_errors    = 0;
    for (int i = 0; i < FB_WORDS; i++) begin
      mirror[i] = '0;
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle outputs before the scanner is enabled
    repeat (3) begin
      @(negedge clk);
      assert (gfx_ready == 1'b1 && underrun == 1'b0 && vga_out.hsync == 1'b1 &&
              vga_out.vsync == 1'b1 && vga_out.pixel == '0) else begin
        $display("Mismatch reset state: gfx_ready %h underrun %h vga_out %h",
                 gfx_ready, underrun, vga_out);
        reset_errors++;
      end
    end
    report_test("reset_state", reset_errors);

    // fill the whole framebuffer while gfx_valid stays high between pixels
    for (int y = 0; y < V_VISIBLE; y++) begin
      for (int x = 0; x < H_VISIBLE; x++) begin
        send_pixel(x, y, random_pixel());
      end
    end
    gfx_valid = 1'b0;
    repeat (4) @(negedge clk);
    assert (xfer_count == FB_WORDS) else begin
      $display("Mismatch transfer count: got %h expected %h", xfer_count, FB_WORDS);
      flow_errors++;
    end
    report_test("client_flow", flow_errors);

    vga_enable = 1'b1;
    // let the scanner run ahead before the first pixel_ce
    repeat (24) @(negedge clk);
    ce_run = 1'b1;

    // output has reached vertical blanking of the first frame
    wait (pos_count >= V_VISIBLE * H_TOTAL);
    @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      send_pixel(int'($unsigned($random(seed)) % H_VISIBLE),
                 int'($unsigned($random(seed)) % V_VISIBLE), random_pixel());
    end
    gfx_valid = 1'b0;

    wait (pos_count >= FRAME_BEATS);
    report_test("frame_contents", contents_errors);
    report_test("sync_blanking", sync_errors);

    wait (pos_count >= CHECK_BEATS);
    @(negedge clk);
    report_test("rewrite_frame", rewrite_errors);

    total_errors = reset_errors + flow_errors + contents_errors +
                   sync_errors + rewrite_errors;
    $display("tests run: 5, tests failed: %0d, errors: %0d", failed_tests, total_errors);
    if ((failed_tests == 0) && (total_errors == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/gfx_pkg.sv
logic/fb_writer.sv
logic/fb_memory.sv
logic/vga_scanner.sv
logic/beat_fifo.sv
logic/gfx_display.sv
testbench/tb_gfx_display.sv

// File: Bender.yml
package:
  name: gfx_display

sources:
  - files:
      - logic/gfx_pkg.sv
      - logic/fb_writer.sv
      - logic/fb_memory.sv
      - logic/vga_scanner.sv
      - logic/beat_fifo.sv
      - logic/gfx_display.sv
  - target: test
    files:
      - testbench/tb_gfx_display.sv
